// File: verilog/mist_glue_settings.svh
`ifndef MIST_GLUE_SETTINGS_SVH
`define MIST_GLUE_SETTINGS_SVH

// pll reconfiguration watchdog, in clk_sys cycles
`define MIST_RECONFIG_TIMEOUT 1000
`define MIST_TIMER_W 10

// back porch blank length in pixels
`define MIST_PORCH_TV_LEN 255
`define MIST_PORCH_VGA_LEN 63
`define MIST_PORCH_CNT_W 8

// download indices whose data goes to RAM
`define MIST_LOADER_IDX_ROM 1
`define MIST_LOADER_IDX_EXT 2

`endif

// File: verilog/mist_glue_pkg.sv
package mist_glue_pkg;

	// pixel base clock selection from the core
	// 00 and 11 are the TV rates
	typedef enum logic [1:0] {
		PIX_24M     = 2'b00,
		PIX_25M     = 2'b01,
		PIX_36M     = 2'b10,
		PIX_24M_ALT = 2'b11
	} pixbase_t;

	// core colour, 4 bits per channel
	typedef struct packed {
		logic [3:0] r;
		logic [3:0] g;
		logic [3:0] b;
	} rgb4_t;

	// vga colour, 6 bits per channel
	typedef struct packed {
		logic [5:0] r;
		logic [5:0] g;
		logic [5:0] b;
	} rgb6_t;

	typedef struct packed {
		logic hs;
		logic vs;
	} sync_t;

	// one word from the rom loader
	typedef struct packed {
		logic        we;
		logic [3:0]  sel;
		logic [23:0] addr;
		logic [31:0] dat;
	} loader_wr_t;

	// wishbone style ram request, write side only
	typedef struct packed {
		logic        we;
		logic [3:0]  sel;
		logic [25:0] adr;
		logic [31:0] dat;
		logic        stb;
		logic        cyc;
	} mem_req_t;

endpackage

// File: verilog/reconfig_timer.sv
`timescale 1ns/1ps

`include "mist_glue_settings.svh"

module reconfig_timer (
	input  logic clk_sys,
	input  logic rst_n_i,
	input  logic start_i,
	input  logic run_i,
	output logic expire_o
);

	logic [`MIST_TIMER_W-1:0] count;

	// load on start, then count down while the sequencer is running
	always_ff @(posedge clk_sys) begin
		if (!rst_n_i) begin
			count <= '0;
		end else if (start_i) begin
			count <= `MIST_TIMER_W'(`MIST_RECONFIG_TIMEOUT);
		end else if (run_i) begin
			count <= count - 1'b1;
		end
	end

	// last cycle of the allowed window
	assign expire_o = run_i && (count == `MIST_TIMER_W'(1));

endmodule

// File: verilog/pll_reconfig_seq.sv
`timescale 1ns/1ps

module pll_reconfig_seq (
	input  logic                   clk_sys,
	input  logic                   rst_n_i,
	input  mist_glue_pkg::pixbase_t pixbase_sel_i,
	input  logic                   pll_busy_i,
	output logic                   pll_write_from_rom_o,
	output logic                   pll_reconfig_o,
	output logic                   pll_reconfig_reset_o
);

	typedef enum logic [1:0] {
		ST_IDLE   = 2'b00,
		ST_SETTLE = 2'b01,
		ST_WAIT   = 2'b10,
		ST_RUN    = 2'b11
	} state_t;

	state_t                  state;
	mist_glue_pkg::pixbase_t sel_q;
	logic                    timer_start;
	logic                    timer_run;
	logic                    timer_expire;

	// timer armed together with the reconfig strobe
	assign timer_start = (state == ST_WAIT) && !pll_busy_i;
	assign timer_run   = (state == ST_RUN);

	reconfig_timer u_timer (
		.clk_sys  (clk_sys),
		.rst_n_i  (rst_n_i),
		.start_i  (timer_start),
		.run_i    (timer_run),
		.expire_o (timer_expire)
	);

	always_ff @(posedge clk_sys) begin
		if (!rst_n_i) begin
			state                <= ST_IDLE;
			sel_q                <= mist_glue_pkg::PIX_24M;
			pll_write_from_rom_o <= 1'b0;
			pll_reconfig_o       <= 1'b0;
			pll_reconfig_reset_o <= 1'b0;
		end else begin
			// strobes are single cycle
			pll_write_from_rom_o <= 1'b0;
			pll_reconfig_o       <= 1'b0;
			pll_reconfig_reset_o <= 1'b0;
			case (state)
				ST_IDLE: begin
					sel_q <= pixbase_sel_i;
					if (sel_q != pixbase_sel_i) begin
						pll_write_from_rom_o <= 1'b1;
						state                <= ST_SETTLE;
					end
				end
				// give busy a cycle to rise after the rom write request
				ST_SETTLE: state <= ST_WAIT;
				ST_WAIT: begin
					if (!pll_busy_i) begin
						pll_reconfig_o <= 1'b1;
						state          <= ST_RUN;
					end
				end
				ST_RUN: begin
					// block stuck busy, kick it
					if (timer_expire) begin
						pll_reconfig_reset_o <= 1'b1;
					end
					if (timer_expire || (!pll_reconfig_o && !pll_busy_i)) begin
						state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

// File: verilog/video_porch_blank.sv
`timescale 1ns/1ps

`include "mist_glue_settings.svh"

module video_porch_blank (
	input  logic                    clk_sys,
	input  logic                    rst_n_i,
	input  mist_glue_pkg::pixbase_t pixbase_sel_i,
	input  logic                    ypbpr_i,
	input  mist_glue_pkg::rgb4_t    core_rgb_i,
	input  mist_glue_pkg::sync_t    core_sync_i,
	output mist_glue_pkg::rgb6_t    vga_rgb_o,
	output mist_glue_pkg::sync_t    vga_sync_o
);

	mist_glue_pkg::rgb4_t          rgb_q;
	mist_glue_pkg::sync_t          sync_q;
	logic [`MIST_PORCH_CNT_W-1:0] pix_cnt;
	logic [`MIST_PORCH_CNT_W-1:0] cnt_end;
	logic                          tv_mode;
	logic                          porch_done;
	logic                          composite;

	// 24 MHz rates are the TV modes
	assign tv_mode    = (pixbase_sel_i[0] == pixbase_sel_i[1]);
	assign cnt_end    = tv_mode ? `MIST_PORCH_CNT_W'(`MIST_PORCH_TV_LEN)
	                            : `MIST_PORCH_CNT_W'(`MIST_PORCH_VGA_LEN);
	assign porch_done = (pix_cnt >= cnt_end);
	assign composite  = tv_mode || ypbpr_i;

	always_ff @(posedge clk_sys) begin
		if (!rst_n_i) begin
			sync_q  <= '0;
			pix_cnt <= '0;
			rgb_q   <= '0;
		end else begin
			sync_q <= core_sync_i;
			// count pixels from the rising edge of hs, then hold
			if (!sync_q.hs) begin
				pix_cnt <= '0;
			end else if (!porch_done) begin
				pix_cnt <= pix_cnt + 1'b1;
			end
			// force black over the back porch
			if (porch_done) begin
				rgb_q <= core_rgb_i;
			end else begin
				rgb_q <= '0;
			end
		end
	end

	// widen by repeating the top bits
	assign vga_rgb_o.r = {rgb_q.r, rgb_q.r[3:2]};
	assign vga_rgb_o.g = {rgb_q.g, rgb_q.g[3:2]};
	assign vga_rgb_o.b = {rgb_q.b, rgb_q.b[3:2]};

	// csync on hs, vs held high
	assign vga_sync_o.hs = composite ? ~(sync_q.hs ^ sync_q.vs) : sync_q.hs;
	assign vga_sync_o.vs = composite ? 1'b1 : sync_q.vs;

endmodule

// File: verilog/loader_mem_arbiter.sv
`timescale 1ns/1ps

`include "mist_glue_settings.svh"

module loader_mem_arbiter (
	input  logic                      clk_sys,
	input  logic                      rst_n_i,
	input  logic                      downloading_i,
	input  logic [7:0]                dio_index_i,
	input  mist_glue_pkg::loader_wr_t loader_i,
	input  mist_glue_pkg::mem_req_t   core_req_i,
	output mist_glue_pkg::mem_req_t   ram_req_o,
	input  logic                      ram_ack_i,
	input  logic                      ram_ready_i,
	output logic                      core_ack_o,
	output logic                      core_reset_o
);

	logic loader_active;
	logic loader_active_q;
	logic loader_stb;
	logic rom_ready;

	// only rom and extension images go to ram
	assign loader_active = downloading_i &&
		((dio_index_i == 8'(`MIST_LOADER_IDX_ROM)) ||
		 (dio_index_i == 8'(`MIST_LOADER_IDX_EXT)));

	always_ff @(posedge clk_sys) begin
		if (!rst_n_i) begin
			loader_active_q <= 1'b0;
			loader_stb      <= 1'b0;
			rom_ready       <= 1'b0;
		end else begin
			loader_active_q <= loader_active;
			// download finished, rom image is in place
			if (loader_active_q && !loader_active) begin
				rom_ready <= 1'b1;
			end
			// strobe held until the ram acknowledges
			if (loader_i.we) begin
				loader_stb <= 1'b1;
			end else if (ram_ack_i) begin
				loader_stb <= 1'b0;
			end
		end
	end

	always_comb begin
		if (loader_active) begin
			ram_req_o.we  = 1'b1;
			ram_req_o.sel = loader_i.sel;
			ram_req_o.adr = {2'b00, loader_i.addr[23:2], 2'b00};
			ram_req_o.dat = loader_i.dat;
			ram_req_o.stb = loader_stb;
			ram_req_o.cyc = loader_stb;
			// core sees no ack while the loader owns the bus
			core_ack_o    = 1'b0;
		end else begin
			ram_req_o     = core_req_i;
			// word aligned, 16 MB window
			ram_req_o.adr = {2'b00, core_req_i.adr[23:2], 2'b00};
			core_ack_o    = ram_ack_i;
		end
	end

	// hold the core until memory and rom are both ready
	assign core_reset_o = !ram_ready_i || !rom_ready;

endmodule

// File: verilog/mist_glue_top.sv
`timescale 1ns/1ps

module mist_glue_top (
	input  logic                      clk_sys,
	input  logic                      rst_n_i,

	// pll reconfiguration
	input  mist_glue_pkg::pixbase_t   pixbase_sel_i,
	input  logic                      pll_busy_i,
	output logic                      pll_write_from_rom_o,
	output logic                      pll_reconfig_o,
	output logic                      pll_reconfig_reset_o,

	// video
	input  mist_glue_pkg::rgb4_t      core_rgb_i,
	input  mist_glue_pkg::sync_t      core_sync_i,
	input  logic                      ypbpr_i,
	output mist_glue_pkg::rgb6_t      vga_rgb_o,
	output mist_glue_pkg::sync_t      vga_sync_o,

	// rom loader
	input  logic                      downloading_i,
	input  logic [7:0]                dio_index_i,
	input  mist_glue_pkg::loader_wr_t loader_i,

	// ram bus
	input  mist_glue_pkg::mem_req_t   core_req_i,
	output mist_glue_pkg::mem_req_t   ram_req_o,
	input  logic                      ram_ack_i,
	input  logic                      ram_ready_i,
	output logic                      core_ack_o,
	output logic                      core_reset_o
);

	// steps the external reconfig block on a clock change
	pll_reconfig_seq u_pll_seq (
		.clk_sys              (clk_sys),
		.rst_n_i              (rst_n_i),
		.pixbase_sel_i        (pixbase_sel_i),
		.pll_busy_i           (pll_busy_i),
		.pll_write_from_rom_o (pll_write_from_rom_o),
		.pll_reconfig_o       (pll_reconfig_o),
		.pll_reconfig_reset_o (pll_reconfig_reset_o)
	);

	// porch blanking and sync selection
	video_porch_blank u_video (
		.clk_sys       (clk_sys),
		.rst_n_i       (rst_n_i),
		.pixbase_sel_i (pixbase_sel_i),
		.ypbpr_i       (ypbpr_i),
		.core_rgb_i    (core_rgb_i),
		.core_sync_i   (core_sync_i),
		.vga_rgb_o     (vga_rgb_o),
		.vga_sync_o    (vga_sync_o)
	);

	// loader takes over the ram during downloads
	loader_mem_arbiter u_arbiter (
		.clk_sys       (clk_sys),
		.rst_n_i       (rst_n_i),
		.downloading_i (downloading_i),
		.dio_index_i   (dio_index_i),
		.loader_i      (loader_i),
		.core_req_i    (core_req_i),
		.ram_req_o     (ram_req_o),
		.ram_ack_i     (ram_ack_i),
		.ram_ready_i   (ram_ready_i),
		.core_ack_o    (core_ack_o),
		.core_reset_o  (core_reset_o)
	);

endmodule

// File: test/tb_mist_glue.sv
`timescale 1ns/1ps

module tb_mist_glue;

	localparam logic [1:0] K_RECONF = 2'd0;
	localparam logic [1:0] K_VIDEO  = 2'd1;
	localparam logic [1:0] K_MEM    = 2'd2;
	localparam int NUM_ROWS = 12;

	// one test step with its expected results
	typedef struct packed {
		logic [1:0] kind;
		logic [1:0] sel;
		logic       ypbpr;
		logic       hang;
		logic       exp_seq;
		logic       dl;
		logic [7:0] idx;
		logic       ready;
		logic       exp_comp;
		logic       exp_loader;
		logic [8:0] blank_to;
		logic [8:0] show_from;
	} row_t;

	logic                      clk_sys;
	logic                      rst_n_i;
	mist_glue_pkg::pixbase_t   pixbase_sel_i;
	logic                      pll_busy_i;
	logic                      pll_write_from_rom_o;
	logic                      pll_reconfig_o;
	logic                      pll_reconfig_reset_o;
	mist_glue_pkg::rgb4_t      core_rgb_i;
	mist_glue_pkg::sync_t      core_sync_i;
	logic                      ypbpr_i;
	mist_glue_pkg::rgb6_t      vga_rgb_o;
	mist_glue_pkg::sync_t      vga_sync_o;
	logic                      downloading_i;
	logic [7:0]                dio_index_i;
	mist_glue_pkg::loader_wr_t loader_i;
	mist_glue_pkg::mem_req_t   core_req_i;
	mist_glue_pkg::mem_req_t   ram_req_o;
	logic                      ram_ack_i;
	logic                      ram_ready_i;
	logic                      core_ack_o;
	logic                      core_reset_o;

	row_t        rows [NUM_ROWS];
	logic [31:0] lfsr_state = 32'ha79f781f;
	// rom image complete as seen from outside
	logic        rom_done_exp = 1'b0;

	mist_glue_top dut (
		.clk_sys              (clk_sys),
		.rst_n_i              (rst_n_i),
		.pixbase_sel_i        (pixbase_sel_i),
		.pll_busy_i           (pll_busy_i),
		.pll_write_from_rom_o (pll_write_from_rom_o),
		.pll_reconfig_o       (pll_reconfig_o),
		.pll_reconfig_reset_o (pll_reconfig_reset_o),
		.core_rgb_i           (core_rgb_i),
		.core_sync_i          (core_sync_i),
		.ypbpr_i              (ypbpr_i),
		.vga_rgb_o            (vga_rgb_o),
		.vga_sync_o           (vga_sync_o),
		.downloading_i        (downloading_i),
		.dio_index_i          (dio_index_i),
		.loader_i             (loader_i),
		.core_req_i           (core_req_i),
		.ram_req_o            (ram_req_o),
		.ram_ack_i            (ram_ack_i),
		.ram_ready_i          (ram_ready_i),
		.core_ack_o           (core_ack_o),
		.core_reset_o         (core_reset_o)
	);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	// galois lfsr, one step per bit
	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] val;
		logic        bit_out;
		int          i;
		val = '0;
		for (i = 0; i < n; i++) begin
			bit_out    = lfsr_state[0];
			lfsr_state = {1'b0, lfsr_state[31:1]} ^ (bit_out ? 32'h80200003 : 32'h0);
			val        = {val[30:0], bit_out};
		end
		return val;
	endfunction

	// each channel is the 4-bit value followed by its top two bits
	function automatic mist_glue_pkg::rgb6_t widen_colour(input mist_glue_pkg::rgb4_t c);
		mist_glue_pkg::rgb6_t w;
		w.r = {c.r, c.r[3], c.r[2]};
		w.g = {c.g, c.g[3], c.g[2]};
		w.b = {c.b, c.b[3], c.b[2]};
		return w;
	endfunction

	task automatic compare(input logic [95:0] got, input logic [95:0] exp, input string what);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s, got %0h expected %0h", $time, what, got, exp);
			$display("SIMULATION FAILED");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	task automatic abort_run(input string why);
		$display("Error at %0t: %s", $time, why);
		$display("SIMULATION FAILED");
		$fatal(1, "run aborted");
	endtask

	function automatic row_t make_row(input logic [1:0] kind, input logic [1:0] sel,
			input logic ypbpr, input logic hang, input logic exp_seq, input logic dl,
			input logic [7:0] idx, input logic ready, input logic exp_comp,
			input logic exp_loader, input logic [8:0] blank_to, input logic [8:0] show_from);
		row_t r;
		r.kind       = kind;
		r.sel        = sel;
		r.ypbpr      = ypbpr;
		r.hang       = hang;
		r.exp_seq    = exp_seq;
		r.dl         = dl;
		r.idx        = idx;
		r.ready      = ready;
		r.exp_comp   = exp_comp;
		r.exp_loader = exp_loader;
		r.blank_to   = blank_to;
		r.show_from  = show_from;
		return r;
	endfunction

	task automatic load_table();
		// pll sequence, unchanged selection, stuck busy, recovery
		rows[0]  = make_row(K_RECONF, 2'b01, 0, 0, 1, 0, 8'd0, 0, 0, 0, 9'd0, 9'd0);
		rows[1]  = make_row(K_RECONF, 2'b01, 0, 0, 0, 0, 8'd0, 0, 0, 0, 9'd0, 9'd0);
		rows[2]  = make_row(K_RECONF, 2'b10, 0, 1, 1, 0, 8'd0, 0, 0, 0, 9'd0, 9'd0);
		rows[3]  = make_row(K_RECONF, 2'b11, 0, 0, 1, 0, 8'd0, 0, 0, 0, 9'd0, 9'd0);
		// vga separate sync, tv composite, vga with ypbpr
		rows[4]  = make_row(K_VIDEO, 2'b01, 0, 0, 0, 0, 8'd0, 0, 0, 0, 9'd55, 9'd70);
		rows[5]  = make_row(K_VIDEO, 2'b00, 0, 0, 0, 0, 8'd0, 0, 1, 0, 9'd250, 9'd260);
		rows[6]  = make_row(K_VIDEO, 2'b10, 1, 0, 0, 0, 8'd0, 0, 1, 0, 9'd55, 9'd70);
		// bus ownership and core reset release
		rows[7]  = make_row(K_MEM, 2'b10, 0, 0, 0, 0, 8'd0, 0, 0, 0, 9'd0, 9'd0);
		rows[8]  = make_row(K_MEM, 2'b10, 0, 0, 0, 1, 8'd3, 1, 0, 0, 9'd0, 9'd0);
		rows[9]  = make_row(K_MEM, 2'b10, 0, 0, 0, 1, 8'd1, 1, 0, 1, 9'd0, 9'd0);
		rows[10] = make_row(K_MEM, 2'b10, 0, 0, 0, 0, 8'd0, 0, 0, 0, 9'd0, 9'd0);
		rows[11] = make_row(K_MEM, 2'b10, 0, 0, 0, 1, 8'd2, 1, 0, 1, 9'd0, 9'd0);
	endtask

	task automatic run_reconfig(input row_t r);
		int n;
		@(posedge clk_sys);
		#1;
		pixbase_sel_i = mist_glue_pkg::pixbase_t'(r.sel);
		if (!r.exp_seq) begin
			repeat (20) begin
				@(negedge clk_sys);
				compare({pll_write_from_rom_o, pll_reconfig_o, pll_reconfig_reset_o}, 3'b000,
					"pll strobe without a selection change");
			end
		end else begin
			n = 0;
			@(negedge clk_sys);
			while (!pll_write_from_rom_o) begin
				if (n == 4)
					abort_run("no ROM write strobe after a selection change");
				n++;
				@(negedge clk_sys);
			end
			n = 0;
			@(negedge clk_sys);
			while (!pll_reconfig_o) begin
				compare({pll_write_from_rom_o, pll_reconfig_reset_o}, 2'b00,
					"extra strobe before reconfigure");
				if (n == 8)
					abort_run("no reconfigure strobe after the ROM write");
				n++;
				@(negedge clk_sys);
			end
			// pll model goes busy after the reconfigure strobe
			@(posedge clk_sys);
			#1;
			pll_busy_i = 1'b1;
			if (r.hang) begin
				n = 0;
				while (!pll_reconfig_reset_o) begin
					@(negedge clk_sys);
					n++;
					if (n > 1100)
						abort_run("PLL reset strobe missing while busy stuck high");
					if (!pll_reconfig_reset_o)
						compare({pll_write_from_rom_o, pll_reconfig_o}, 2'b00,
							"strobe while waiting for the watchdog");
				end
				compare(n, 1000, "cycles from reconfigure to PLL reset");
				@(negedge clk_sys);
				compare(pll_reconfig_reset_o, 1'b0, "PLL reset strobe length");
				@(posedge clk_sys);
				#1;
				pll_busy_i = 1'b0;
			end else begin
				repeat (4) begin
					@(negedge clk_sys);
					compare({pll_write_from_rom_o, pll_reconfig_o, pll_reconfig_reset_o},
						3'b000, "pll strobe while the PLL is busy");
				end
				@(posedge clk_sys);
				#1;
				pll_busy_i = 1'b0;
			end
			repeat (30) begin
				@(negedge clk_sys);
				compare({pll_write_from_rom_o, pll_reconfig_o, pll_reconfig_reset_o}, 3'b000,
					"pll strobe after the sequence");
			end
		end
	endtask

	task automatic run_video(input row_t r);
		mist_glue_pkg::rgb4_t prev_rgb;
		mist_glue_pkg::sync_t prev_sync;
		mist_glue_pkg::sync_t exp_sync;
		logic [31:0]          rnd;
		int                   k;
		@(posedge clk_sys);
		#1;
		pixbase_sel_i = mist_glue_pkg::pixbase_t'(r.sel);
		ypbpr_i       = r.ypbpr;
		core_sync_i   = '0;
		core_rgb_i    = '0;
		repeat (4) @(posedge clk_sys);
		#1;
		// hs rises here, cycle 0
		core_sync_i.hs = 1'b1;
		for (k = 1; k <= r.show_from + 50; k++) begin
			@(posedge clk_sys);
			#1;
			prev_rgb  = core_rgb_i;
			prev_sync = core_sync_i;
			rnd       = random_bits(12);
			core_rgb_i = rnd[11:0];
			rnd       = random_bits(2);
			// hs stays high through the porch, random afterwards
			core_sync_i.hs = (k <= r.show_from + 20) ? 1'b1 : rnd[1];
			core_sync_i.vs = rnd[0];
			@(negedge clk_sys);
			if (r.exp_comp) begin
				exp_sync.hs = (prev_sync.hs == prev_sync.vs);
				exp_sync.vs = 1'b1;
			end else begin
				exp_sync = prev_sync;
			end
			compare(vga_sync_o, exp_sync, "video sync");
			if (k >= 10 && k <= r.blank_to)
				compare(vga_rgb_o, 18'h0, "colour inside the porch");
			else if (k >= r.show_from && k <= r.show_from + 20)
				compare(vga_rgb_o, widen_colour(prev_rgb), "colour after the porch");
		end
	endtask

	task automatic check_bus(input logic loader_owns, input logic stb_exp);
		mist_glue_pkg::mem_req_t exp_req;
		if (loader_owns) begin
			exp_req.we  = 1'b1;
			exp_req.sel = loader_i.sel;
			exp_req.adr = {2'b00, loader_i.addr} & 26'h3fffffc;
			exp_req.dat = loader_i.dat;
			exp_req.stb = stb_exp;
			exp_req.cyc = stb_exp;
		end else begin
			exp_req     = core_req_i;
			exp_req.adr = core_req_i.adr & 26'h0fffffc;
		end
		compare(ram_req_o, exp_req, "ram request");
		compare(core_ack_o, loader_owns ? 1'b0 : ram_ack_i, "core acknowledge");
		compare(core_reset_o, !(ram_ready_i && rom_done_exp), "core reset");
	endtask

	task automatic new_words(input logic we);
		logic [31:0] rnd;
		rnd = random_bits(28);
		loader_i.we   = we;
		loader_i.sel  = rnd[27:24];
		loader_i.addr = rnd[23:0];
		loader_i.dat  = random_bits(32);
		rnd = random_bits(32);
		core_req_i.we  = rnd[31];
		core_req_i.sel = rnd[30:27];
		core_req_i.adr = rnd[25:0];
		core_req_i.stb = rnd[26];
		core_req_i.cyc = rnd[26];
		core_req_i.dat = random_bits(32);
	endtask

	task automatic run_mem(input row_t r);
		int          t;
		logic [31:0] w;
		@(posedge clk_sys);
		#1;
		ram_ready_i   = r.ready;
		downloading_i = r.dl;
		dio_index_i   = r.idx;
		ram_ack_i     = 1'b0;
		new_words(1'b0);
		@(negedge clk_sys);
		check_bus(r.exp_loader, 1'b0);
		for (t = 0; t < 4; t++) begin
			@(posedge clk_sys);
			#1;
			new_words(1'b1);
			@(negedge clk_sys);
			check_bus(r.exp_loader, 1'b0);
			@(posedge clk_sys);
			#1;
			loader_i.we = 1'b0;
			@(negedge clk_sys);
			check_bus(r.exp_loader, 1'b1);
			w = random_bits(2);
			repeat (w) begin
				@(posedge clk_sys);
				#1;
				@(negedge clk_sys);
				check_bus(r.exp_loader, 1'b1);
			end
			@(posedge clk_sys);
			#1;
			ram_ack_i = 1'b1;
			@(negedge clk_sys);
			check_bus(r.exp_loader, 1'b1);
			@(posedge clk_sys);
			#1;
			ram_ack_i = 1'b0;
			@(negedge clk_sys);
			check_bus(r.exp_loader, 1'b0);
		end
		// end of the download
		@(posedge clk_sys);
		#1;
		downloading_i = 1'b0;
		@(negedge clk_sys);
		check_bus(1'b0, 1'b0);
		@(posedge clk_sys);
		if (r.exp_loader)
			rom_done_exp = 1'b1;
		@(negedge clk_sys);
		check_bus(1'b0, 1'b0);
	endtask

	initial begin
		int i;
		rst_n_i       = 1'b0;
		pixbase_sel_i = mist_glue_pkg::PIX_24M;
		pll_busy_i    = 1'b0;
		core_rgb_i    = '0;
		core_sync_i   = '0;
		ypbpr_i       = 1'b0;
		downloading_i = 1'b0;
		dio_index_i   = '0;
		loader_i      = '0;
		core_req_i    = '0;
		ram_ack_i     = 1'b0;
		ram_ready_i   = 1'b0;
		load_table();
		repeat (3) @(posedge clk_sys);
		#1;
		rst_n_i = 1'b1;
		@(negedge clk_sys);
		compare({pll_write_from_rom_o, pll_reconfig_o, pll_reconfig_reset_o}, 3'b000,
			"pll strobes after reset");
		compare(core_reset_o, 1'b1, "core reset after reset");
		compare(vga_rgb_o, 18'h0, "colour after reset");
		for (i = 0; i < NUM_ROWS; i++) begin
			case (rows[i].kind)
				K_RECONF: run_reconfig(rows[i]);
				K_VIDEO:  run_video(rows[i]);
				default:  run_mem(rows[i]);
			endcase
		end
		$display("SIMULATION PASSED");
		$finish;
	end

	// limit scales with the number of table rows
	initial begin
		repeat (NUM_ROWS * 2000) @(posedge clk_sys);
		abort_run("watchdog expired before the table was done");
	end

endmodule

// File: filelist.f
+incdir+verilog
verilog/mist_glue_pkg.sv
verilog/reconfig_timer.sv
verilog/pll_reconfig_seq.sv
verilog/video_porch_blank.sv
verilog/loader_mem_arbiter.sv
verilog/mist_glue_top.sv
test/tb_mist_glue.sv

// File: Bender.yml
package:
  name: mist_glue

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/mist_glue_pkg.sv
      - verilog/reconfig_timer.sv
      - verilog/pll_reconfig_seq.sv
      - verilog/video_porch_blank.sv
      - verilog/loader_mem_arbiter.sv
      - verilog/mist_glue_top.sv
  - target: test
    files:
      - test/tb_mist_glue.sv
